/* Bender.yml */
package:
  name: riscv_control

sources:
  - src/riscv_control_pkg.sv
  - src/decode_if.sv
  - src/instr_decoder.sv
  - src/control_table.sv
  - src/control_unit.sv
  - target: simulation
    files:
      - verification/control_unit_sva.sv
      - verification/control_unit_tb.sv

/* riscv_control.f */
src/riscv_control_pkg.sv
src/decode_if.sv
src/instr_decoder.sv
src/control_table.sv
src/control_unit.sv
verification/control_unit_sva.sv
verification/control_unit_tb.sv

/* src/control_table.sv */
`timescale 1ns/10ps

module control_table
    import riscv_control_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    decode_if.consumer dec,
    output logic       pc_en,
    output logic       branch,
    output logic       jump,
    output logic       mem_read,
    output logic       mem_to_reg,
    output logic       mem_write,
    output logic       alu_src,
    output logic       reg_write,
    output logic       signed_inst,
    output rf_sel_e    rf_sel,
    output mem_size_e  mem_size,
    output alu_op_e    alu_op
);

    typedef struct packed {
        logic      pc_en;
        logic      branch;
        logic      jump;
        logic      mem_read;
        logic      mem_to_reg;
        logic      mem_write;
        logic      alu_src;
        logic      reg_write;
        logic      signed_inst;
        rf_sel_e   rf_sel;
        mem_size_e mem_size;
        alu_op_e   alu_op;
    } ctrl_t;

    ctrl_t nxt;
    ctrl_t ctrl_q;

    // Same size encoding for loads and stores
    function automatic mem_size_e size_of(input logic [FUNCT3_W-1:0] funct3);
        mem_size_e size;
        case (funct3)
            F3_BYTE, F3_BYTE_U: size = SIZE_BYTE;
            F3_HALF, F3_HALF_U: size = SIZE_HALF;
            default:            size = SIZE_WORD;
        endcase
        return size;
    endfunction

    always_comb
    begin
        nxt = '0;
        if (!(dec.op_class inside {OPC_NONE, OPC_SYSTEM, OPC_FENCE}))
        begin
            nxt.pc_en = 1'b1;  // Illegal funct still advances the PC
            if (dec.legal)
            begin
                case (dec.op_class)
                    OPC_LUI, OPC_AUIPC:
                    begin
                        nxt.alu_src     = 1'b1;
                        nxt.reg_write   = 1'b1;
                        nxt.signed_inst = 1'b1;
                        if (dec.op_class == OPC_AUIPC)
                        begin
                            nxt.alu_op = ALU_OP_FUNCT;
                            nxt.rf_sel = RF_PC_IMM;
                        end
                        else
                            nxt.alu_op = ALU_OP_PASS_B;
                    end
                    OPC_JAL, OPC_JALR:
                    begin
                        nxt.branch      = (dec.op_class == OPC_JAL);
                        nxt.jump        = 1'b1;
                        nxt.alu_src     = 1'b1;
                        nxt.reg_write   = 1'b1;
                        nxt.signed_inst = 1'b1;
                        nxt.rf_sel      = RF_PC_NEXT;  // Link address
                    end
                    OPC_BRANCH:
                    begin
                        nxt.branch      = 1'b1;
                        nxt.alu_op      = ALU_OP_CMP;
                        nxt.signed_inst = (dec.funct3 != F3_BLTU) && (dec.funct3 != F3_BGEU);
                    end
                    OPC_LOAD:
                    begin
                        nxt.mem_read    = 1'b1;
                        nxt.mem_to_reg  = 1'b1;
                        nxt.alu_src     = 1'b1;
                        nxt.reg_write   = 1'b1;
                        nxt.mem_size    = size_of(dec.funct3);
                        nxt.signed_inst = dec.funct3 inside {F3_BYTE, F3_HALF, F3_WORD};
                    end
                    OPC_STORE:
                    begin
                        nxt.mem_write   = 1'b1;
                        nxt.alu_src     = 1'b1;
                        nxt.signed_inst = 1'b1;
                        nxt.mem_size    = size_of(dec.funct3);
                    end
                    OPC_ARITH_I:
                    begin
                        nxt.alu_src     = 1'b1;
                        nxt.reg_write   = 1'b1;
                        nxt.signed_inst = 1'b1;
                    end
                    OPC_ARITH_R:
                    begin
                        nxt.reg_write   = 1'b1;
                        nxt.alu_op      = ALU_OP_FUNCT;
                        nxt.signed_inst = (dec.funct3 != F3_SLTU);
                    end
                    OPC_ARITH_M:
                    begin
                        nxt.reg_write   = 1'b1;
                        nxt.alu_op      = ALU_OP_MULDIV;
                        nxt.signed_inst = !(dec.funct3 inside {F3_MULHU, F3_DIVU, F3_REMU});
                    end
                    default:
                        ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ctrl_q <= '0;
        else
            ctrl_q <= nxt;
    end

    assign pc_en       = ctrl_q.pc_en;
    assign branch      = ctrl_q.branch;
    assign jump        = ctrl_q.jump;
    assign mem_read    = ctrl_q.mem_read;
    assign mem_to_reg  = ctrl_q.mem_to_reg;
    assign mem_write   = ctrl_q.mem_write;
    assign alu_src     = ctrl_q.alu_src;
    assign reg_write   = ctrl_q.reg_write;
    assign signed_inst = ctrl_q.signed_inst;
    assign rf_sel      = ctrl_q.rf_sel;
    assign mem_size    = ctrl_q.mem_size;
    assign alu_op      = ctrl_q.alu_op;

endmodule

/* src/control_unit.sv */
`timescale 1ns/10ps

module control_unit
    import riscv_control_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [INST_W-1:0] inst,
    output logic              pc_en,
    output logic              branch,
    output logic              jump,
    output logic              mem_read,
    output logic              mem_to_reg,
    output logic              mem_write,
    output logic              alu_src,
    output logic              reg_write,
    output logic              signed_inst,
    output rf_sel_e           rf_sel,
    output mem_size_e         mem_size,
    output alu_op_e           alu_op
);

    decode_if dec_bus ();  // Combinational, same cycle as inst

    instr_decoder i_instr_decoder (
        .inst (inst),
        .dec  (dec_bus.producer)
    );

    // Single register stage, one cycle latency
    control_table i_control_table (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec_bus.consumer),
        .pc_en       (pc_en),
        .branch      (branch),
        .jump        (jump),
        .mem_read    (mem_read),
        .mem_to_reg  (mem_to_reg),
        .mem_write   (mem_write),
        .alu_src     (alu_src),
        .reg_write   (reg_write),
        .signed_inst (signed_inst),
        .rf_sel      (rf_sel),
        .mem_size    (mem_size),
        .alu_op      (alu_op)
    );

endmodule

/* src/decode_if.sv */
`timescale 1ns/10ps

interface decode_if
    import riscv_control_pkg::*;
();

    op_class_e           op_class;
    logic [FUNCT3_W-1:0] funct3;
    logic                legal;   // funct3/funct7 valid for the class
    logic                alt;     // funct7 equals F7_ALT

    modport producer (
        output op_class,
        output funct3,
        output legal,
        output alt
    );

    modport consumer (
        input op_class,
        input funct3,
        input legal,
        input alt
    );

endinterface

/* src/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
    import riscv_control_pkg::*;
(
    input  logic [INST_W-1:0] inst,
    decode_if.producer        dec
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic                f7_std;     // Base or alternate funct7
    op_class_e           op_class;
    logic                legal;

    assign opcode = inst[6:2];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign f7_std = (funct7 == F7_BASE) || (funct7 == F7_ALT);

    // Opcode classification
    always_comb
    begin
        op_class = OPC_NONE;
        if (inst != '0)  // Zero word is a bubble
        begin
            case (opcode)
                OPC_VAL_SYSTEM:  op_class = OPC_SYSTEM;
                OPC_VAL_FENCE:   op_class = OPC_FENCE;
                OPC_VAL_LUI:     op_class = OPC_LUI;
                OPC_VAL_AUIPC:   op_class = OPC_AUIPC;
                OPC_VAL_JAL:     op_class = OPC_JAL;
                OPC_VAL_JALR:    op_class = OPC_JALR;
                OPC_VAL_BRANCH:  op_class = OPC_BRANCH;
                OPC_VAL_LOAD:    op_class = OPC_LOAD;
                OPC_VAL_STORE:   op_class = OPC_STORE;
                OPC_VAL_ARITH_I: op_class = OPC_ARITH_I;
                OPC_VAL_ARITH_R:
                begin
                    if (funct7 == F7_MULDIV)
                        op_class = OPC_ARITH_M;
                    else
                        op_class = OPC_ARITH_R;
                end
                default:         op_class = OPC_NONE;
            endcase
        end
    end

    // funct3/funct7 legality within the class
    always_comb
    begin
        case (op_class)
            OPC_BRANCH:
                legal = (funct3[2:1] != 2'b01);  // 2 and 3 reserved
            OPC_LOAD:
            begin
                case (funct3)
                    F3_BYTE, F3_HALF, F3_WORD, F3_BYTE_U, F3_HALF_U:
                        legal = 1'b1;
                    default:
                        legal = 1'b0;
                endcase
            end
            OPC_STORE:
            begin
                case (funct3)
                    F3_BYTE, F3_HALF, F3_WORD:
                        legal = 1'b1;
                    default:
                        legal = 1'b0;
                endcase
            end
            OPC_ARITH_I:
                legal = (funct3 != F3_SHIFT_R) || f7_std;  // SRLI/SRAI only
            OPC_ARITH_R:
            begin
                if ((funct3 == F3_ADD_SUB) || (funct3 == F3_SHIFT_R))
                    legal = f7_std;
                else
                    legal = 1'b1;  // Any funct7 accepted here
            end
            default:
                legal = 1'b1;
        endcase
    end

    assign dec.op_class = op_class;
    assign dec.funct3   = funct3;
    assign dec.legal    = legal;
    assign dec.alt      = (funct7 == F7_ALT);

endmodule

/* src/riscv_control_pkg.sv */
package riscv_control_pkg;

    localparam int INST_W   = 32;
    localparam int OPCODE_W = 5;   // inst[6:2]
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // Major opcodes, bits 1:0 of the instruction are ignored
    localparam logic [OPCODE_W-1:0] OPC_VAL_LOAD    = 5'b00000;
    localparam logic [OPCODE_W-1:0] OPC_VAL_FENCE   = 5'b00011;
    localparam logic [OPCODE_W-1:0] OPC_VAL_ARITH_I = 5'b00100;
    localparam logic [OPCODE_W-1:0] OPC_VAL_AUIPC   = 5'b00101;
    localparam logic [OPCODE_W-1:0] OPC_VAL_STORE   = 5'b01000;
    localparam logic [OPCODE_W-1:0] OPC_VAL_ARITH_R = 5'b01100;
    localparam logic [OPCODE_W-1:0] OPC_VAL_LUI     = 5'b01101;
    localparam logic [OPCODE_W-1:0] OPC_VAL_BRANCH  = 5'b11000;
    localparam logic [OPCODE_W-1:0] OPC_VAL_JALR    = 5'b11001;
    localparam logic [OPCODE_W-1:0] OPC_VAL_JAL     = 5'b11011;
    localparam logic [OPCODE_W-1:0] OPC_VAL_SYSTEM  = 5'b11100;

    localparam logic [FUNCT7_W-1:0] F7_BASE   = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT    = 7'b0100000;  // SUB, SRA, SRAI
    localparam logic [FUNCT7_W-1:0] F7_MULDIV = 7'b0000001;

    // Load and store access widths
    localparam logic [FUNCT3_W-1:0] F3_BYTE   = 3'd0;
    localparam logic [FUNCT3_W-1:0] F3_HALF   = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_WORD   = 3'd2;
    localparam logic [FUNCT3_W-1:0] F3_BYTE_U = 3'd4;
    localparam logic [FUNCT3_W-1:0] F3_HALF_U = 3'd5;

    // Arithmetic funct3 values with special handling
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'd0;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'd3;
    localparam logic [FUNCT3_W-1:0] F3_SHIFT_R = 3'd5;  // SRL/SRA, SRLI/SRAI

    // Unsigned branch and M-extension variants
    localparam logic [FUNCT3_W-1:0] F3_BLTU  = 3'd6;
    localparam logic [FUNCT3_W-1:0] F3_BGEU  = 3'd7;
    localparam logic [FUNCT3_W-1:0] F3_MULHU = 3'd3;
    localparam logic [FUNCT3_W-1:0] F3_DIVU  = 3'd5;
    localparam logic [FUNCT3_W-1:0] F3_REMU  = 3'd7;

    typedef enum logic [3:0] {
        OPC_NONE,     // Bubble or unknown opcode
        OPC_SYSTEM,
        OPC_FENCE,
        OPC_LUI,
        OPC_AUIPC,
        OPC_JAL,
        OPC_JALR,
        OPC_BRANCH,
        OPC_LOAD,
        OPC_STORE,
        OPC_ARITH_I,
        OPC_ARITH_R,
        OPC_ARITH_M
    } op_class_e;

    typedef enum logic [2:0] {
        ALU_OP_ADDR   = 3'd0,
        ALU_OP_CMP    = 3'd1,
        ALU_OP_FUNCT  = 3'd2,
        ALU_OP_PASS_B = 3'd3,
        ALU_OP_MULDIV = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        RF_ALU     = 2'd0,
        RF_PC_IMM  = 2'd1,
        RF_PC_NEXT = 2'd2
    } rf_sel_e;

    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_BYTE = 2'd2
    } mem_size_e;

endpackage

/* verification/control_unit_sva.sv */
`timescale 1ns/10ps

module control_unit_sva
    import riscv_control_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      pc_en,
    input logic      branch,
    input logic      jump,
    input logic      mem_read,
    input logic      mem_to_reg,
    input logic      mem_write,
    input logic      alu_src,
    input logic      reg_write,
    input logic      signed_inst,
    input rf_sel_e   rf_sel,
    input mem_size_e mem_size,
    input alu_op_e   alu_op
);

    logic [15:0] ctrl_word;

    assign ctrl_word = {pc_en, branch, jump, mem_read, mem_to_reg, mem_write, alu_src,
                        reg_write, signed_inst, rf_sel, mem_size, alu_op};

    reset_clears: assert property (@(posedge clk) rst |=> (ctrl_word == '0))
        else $error("control outputs not cleared after reset");

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write both high");

    read_to_reg: assert property (@(posedge clk) disable iff (rst) mem_read |-> mem_to_reg)
        else $error("mem_read without mem_to_reg");

    jump_links: assert property (@(posedge clk) disable iff (rst)
        jump |-> (rf_sel == RF_PC_NEXT))
        else $error("jump without link select");

endmodule

bind control_unit control_unit_sva i_control_unit_sva (.*);

/* verification/control_unit_tb.sv */
`timescale 1ns/10ps

module control_unit_tb
    import riscv_control_pkg::*;
();

    // Flag bits of the expected control word
    localparam logic [8:0] F_PC  = 9'b100000000;
    localparam logic [8:0] F_BR  = 9'b010000000;
    localparam logic [8:0] F_JMP = 9'b001000000;
    localparam logic [8:0] F_MR  = 9'b000100000;
    localparam logic [8:0] F_M2R = 9'b000010000;
    localparam logic [8:0] F_MW  = 9'b000001000;
    localparam logic [8:0] F_AS  = 9'b000000100;
    localparam logic [8:0] F_RW  = 9'b000000010;
    localparam logic [8:0] F_SG  = 9'b000000001;
    localparam int RESET_CYCLES  = 8;

    logic              clk;
    logic              rst;
    logic [INST_W-1:0] inst;
    logic              pc_en;
    logic              branch;
    logic              jump;
    logic              mem_read;
    logic              mem_to_reg;
    logic              mem_write;
    logic              alu_src;
    logic              reg_write;
    logic              signed_inst;
    rf_sel_e           rf_sel;
    mem_size_e         mem_size;
    alu_op_e           alu_op;

    string             names[$];
    logic [INST_W-1:0] bases[$];
    logic [15:0]       exps[$];

    logic [7:0] lfsr_state;
    int         errors;
    int         checks;
    int         cycles;
    int         limit;

    control_unit i_control_unit (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .pc_en       (pc_en),
        .branch      (branch),
        .jump        (jump),
        .mem_read    (mem_read),
        .mem_to_reg  (mem_to_reg),
        .mem_write   (mem_write),
        .alu_src     (alu_src),
        .reg_write   (reg_write),
        .signed_inst (signed_inst),
        .rf_sel      (rf_sel),
        .mem_size    (mem_size),
        .alu_op      (alu_op)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output logic [4:0] v);
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[3:0], lfsr_state[0]};
        end
    endtask

    // rd, rs1, rs2
    task automatic reg_fields(output logic [INST_W-1:0] f);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        take_bits(5, rd);
        take_bits(5, rs1);
        take_bits(5, rs2);
        f = (INST_W'(rd) << 7) | (INST_W'(rs1) << 15) | (INST_W'(rs2) << 20);
    endtask

    function automatic logic [15:0] ctl(input logic [8:0] flags, input rf_sel_e rf,
                                        input mem_size_e sz, input alu_op_e op);
        return {flags, rf, sz, op};
    endfunction

    task automatic add(input string name, input logic [INST_W-1:0] base,
                       input logic [15:0] exp);
        names.push_back(name);
        bases.push_back(base);
        exps.push_back(exp);
    endtask

    task automatic build_table();
        logic [15:0] zero;
        logic [15:0] pc_only;
        zero    = ctl(9'b0, RF_ALU, SIZE_WORD, ALU_OP_ADDR);
        pc_only = ctl(F_PC, RF_ALU, SIZE_WORD, ALU_OP_ADDR);
        add("bubble", 32'h00000000, zero);
        add("ecall", 32'h00000073, zero);
        add("fence", 32'h0000000F, zero);
        add("unknown_opcode", 32'h0000007F, zero);
        add("lui", 32'hA0000037, ctl(F_PC | F_AS | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_PASS_B));
        add("auipc", 32'h00000017, ctl(F_PC | F_AS | F_RW | F_SG, RF_PC_IMM, SIZE_WORD,
                                       ALU_OP_FUNCT));
        add("jal", 32'h0000006F, ctl(F_PC | F_BR | F_JMP | F_AS | F_RW | F_SG, RF_PC_NEXT,
                                     SIZE_WORD, ALU_OP_ADDR));
        add("jalr", 32'h00000067, ctl(F_PC | F_JMP | F_AS | F_RW | F_SG, RF_PC_NEXT,
                                      SIZE_WORD, ALU_OP_ADDR));
        add("beq", 32'h00000063, ctl(F_PC | F_BR | F_SG, RF_ALU, SIZE_WORD, ALU_OP_CMP));
        add("bne", 32'h00001063, ctl(F_PC | F_BR | F_SG, RF_ALU, SIZE_WORD, ALU_OP_CMP));
        add("branch_f3_2", 32'h00002063, pc_only);
        add("branch_f3_3", 32'h00003063, pc_only);
        add("blt", 32'h00004063, ctl(F_PC | F_BR | F_SG, RF_ALU, SIZE_WORD, ALU_OP_CMP));
        add("bge", 32'h00005063, ctl(F_PC | F_BR | F_SG, RF_ALU, SIZE_WORD, ALU_OP_CMP));
        add("bltu", 32'h00006063, ctl(F_PC | F_BR, RF_ALU, SIZE_WORD, ALU_OP_CMP));
        add("bgeu", 32'h00007063, ctl(F_PC | F_BR, RF_ALU, SIZE_WORD, ALU_OP_CMP));
        add("lb", 32'h00000003, ctl(F_PC | F_MR | F_M2R | F_AS | F_RW | F_SG, RF_ALU,
                                    SIZE_BYTE, ALU_OP_ADDR));
        add("lh", 32'h00001003, ctl(F_PC | F_MR | F_M2R | F_AS | F_RW | F_SG, RF_ALU,
                                    SIZE_HALF, ALU_OP_ADDR));
        add("lw", 32'h00002003, ctl(F_PC | F_MR | F_M2R | F_AS | F_RW | F_SG, RF_ALU,
                                    SIZE_WORD, ALU_OP_ADDR));
        add("load_f3_3", 32'h00003003, pc_only);
        add("lbu", 32'h00004003, ctl(F_PC | F_MR | F_M2R | F_AS | F_RW, RF_ALU,
                                     SIZE_BYTE, ALU_OP_ADDR));
        add("lhu", 32'h00005003, ctl(F_PC | F_MR | F_M2R | F_AS | F_RW, RF_ALU,
                                     SIZE_HALF, ALU_OP_ADDR));
        add("load_f3_6", 32'h00006003, pc_only);
        add("sb", 32'h00000023, ctl(F_PC | F_MW | F_AS | F_SG, RF_ALU, SIZE_BYTE, ALU_OP_ADDR));
        add("sh", 32'h00001023, ctl(F_PC | F_MW | F_AS | F_SG, RF_ALU, SIZE_HALF, ALU_OP_ADDR));
        add("sw", 32'h00002023, ctl(F_PC | F_MW | F_AS | F_SG, RF_ALU, SIZE_WORD, ALU_OP_ADDR));
        add("store_f3_3", 32'h00003023, pc_only);
        add("addi", 32'h00000013, ctl(F_PC | F_AS | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_ADDR));
        add("sltiu", 32'h00003013, ctl(F_PC | F_AS | F_RW | F_SG, RF_ALU, SIZE_WORD,
                                       ALU_OP_ADDR));
        add("srli", 32'h00005013, ctl(F_PC | F_AS | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_ADDR));
        add("srai", 32'h40005013, ctl(F_PC | F_AS | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_ADDR));
        add("shift_i_bad_f7", 32'h02005013, pc_only);
        add("add", 32'h00000033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_FUNCT));
        add("sub", 32'h40000033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_FUNCT));
        add("sll_odd_f7", 32'h04001033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD,
                                            ALU_OP_FUNCT));
        add("sltu", 32'h00003033, ctl(F_PC | F_RW, RF_ALU, SIZE_WORD, ALU_OP_FUNCT));
        add("srl", 32'h00005033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_FUNCT));
        add("sra", 32'h40005033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_FUNCT));
        add("add_bad_f7", 32'h04000033, pc_only);
        add("shift_r_bad_f7", 32'h60005033, pc_only);
        add("mul", 32'h02000033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_MULDIV));
        add("mulhu", 32'h02003033, ctl(F_PC | F_RW, RF_ALU, SIZE_WORD, ALU_OP_MULDIV));
        add("div", 32'h02004033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_MULDIV));
        add("divu", 32'h02005033, ctl(F_PC | F_RW, RF_ALU, SIZE_WORD, ALU_OP_MULDIV));
        add("rem", 32'h02006033, ctl(F_PC | F_RW | F_SG, RF_ALU, SIZE_WORD, ALU_OP_MULDIV));
        add("remu", 32'h02007033, ctl(F_PC | F_RW, RF_ALU, SIZE_WORD, ALU_OP_MULDIV));
        add("bubble_again", 32'h00000000, zero);
    endtask

    function automatic logic [15:0] actual_word();
        return {pc_en, branch, jump, mem_read, mem_to_reg, mem_write, alu_src,
                reg_write, signed_inst, rf_sel, mem_size, alu_op};
    endfunction

    task automatic check_word(input string name, input logic [15:0] exp);
        logic [15:0] act;
        act = actual_word();
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if ((limit > 0) && (cycles > limit))
        begin
            $display("Timeout: run exceeded %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        logic [INST_W-1:0] fields;
        int n;
        rst        = 1'b1;
        inst       = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        limit      = 0;
        lfsr_state = 8'd49;
        build_table();
        n     = bases.size();
        limit = n + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("after_reset", '0);

        // One instruction per cycle, result checked one cycle later
        for (int i = 0; i <= n; i++)
        begin
            @(posedge clk);
            if (i < n)
            begin
                fields = '0;
                if (bases[i] != '0)  // Bubble keeps register fields at zero
                    reg_fields(fields);
                inst <= bases[i] | fields;
            end
            else
                inst <= '0;
            @(negedge clk);
            if (i > 0)
                check_word(names[i-1], exps[i-1]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
